/* logic/ps2_pkg.sv */
/*
  shared definitions for the ps2 keyboard receiver
  frame size, bit counter and scan-code types, prefix codes,
  shift key codes and the ascii value used for unlisted keys
*/
`default_nettype none

package ps2_pkg;

  // ----------------------------------------------------------
  // frame format
  // ----------------------------------------------------------

  // start bit, eight data bits, parity and stop bit
  localparam int frame_bits = 11;

  typedef logic [3:0] bit_count_t;  // counts 0 up to frame_bits
  typedef logic [7:0] scan_code_t;  // one scan code or one ascii byte

  // ----------------------------------------------------------
  // special scan codes
  // ----------------------------------------------------------

  localparam scan_code_t extend_code      = 8'hE0;  // extended key prefix
  localparam scan_code_t release_code     = 8'hF0;  // key release prefix
  localparam scan_code_t left_shift_code  = 8'h12;
  localparam scan_code_t right_shift_code = 8'h59;

  // ascii '.' stands in for any code the table does not list
  localparam scan_code_t ascii_unknown    = 8'h2E;

endpackage

`default_nettype wire

/* logic/ps2_rx_fsm.sv */
/*
  input flops for the keyboard clock and data lines, and the
  four-state machine that tracks the keyboard clock
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_rx_fsm (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk_i,
  input  logic ps2_data_i,
  output logic sample_o,      // one cycle per falling keyboard clock edge
  output logic ps2_data_s_o,  // synced data line
  output logic idle_high_o    // keyboard clock sitting high
);

  typedef enum logic [1:0] {
    st_clk_h,  // line high, waiting for a fall
    st_fall,   // falling edge marker
    st_clk_l,  // line low, waiting for a rise
    st_rise    // rising edge marker
  } state_t;

  logic   ps2_clk_s;  // synced keyboard clock
  state_t state;
  state_t state_next;

  // one flop per line, keeps slow edges out of the fsm
  always_ff @(posedge clk)
  begin
    ps2_clk_s    <= ps2_clk_i;
    ps2_data_s_o <= ps2_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_clk_h;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      st_clk_h:
        if (!ps2_clk_s)
          state_next = st_fall;
      st_fall:
        state_next = st_clk_l;  // markers last exactly one cycle
      st_clk_l:
        if (ps2_clk_s)
          state_next = st_rise;
      st_rise:
        state_next = st_clk_h;
      default:
        state_next = st_clk_h;
    endcase
  end

  assign sample_o    = (state == st_fall);
  assign idle_high_o = (state == st_clk_h);  // watchdog only runs here

endmodule

`default_nettype wire

/* logic/ps2_watchdog_timer.sv */
/*
  idle-line watchdog, flags a frame that stalled with the
  keyboard clock high for too long
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_watchdog_timer #(
  parameter int unsigned watchdog_cycles = 2950  // 60 us at 49.152 MHz
) (
  input  logic clk,
  input  logic reset,
  input  logic idle_high_i,
  output logic expired_o
);

  localparam int cnt_w = $clog2(watchdog_cycles + 1);
  localparam logic [cnt_w-1:0] limit = cnt_w'(watchdog_cycles);

  logic [cnt_w-1:0] count;
  logic             at_limit;

  assign at_limit = (count == limit);

  // saturating count of consecutive idle cycles
  always_ff @(posedge clk)
  begin
    if (reset || !idle_high_i)
      count <= '0;
    else if (!at_limit)
      count <= count + cnt_w'(1);
  end

  // gated by idle so the fall that ends the wait is not treated as expiry
  assign expired_o = at_limit && idle_high_i;

endmodule

`default_nettype wire

/* logic/ps2_frame_shifter.sv */
/*
  frame shift register and bit counter
  signals a complete frame and presents its data byte
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_shifter (
  input  logic                clk,
  input  logic                reset,
  input  logic                sample_i,      // falling keyboard clock edge
  input  logic                ps2_data_s_i,
  input  logic                expired_i,     // watchdog says line went idle
  output logic                frame_done_o,
  output ps2_pkg::scan_code_t code_o
);

  import ps2_pkg::*;

  logic [frame_bits-1:0] frame_q;    // bits arrive lsb first
  bit_count_t            bit_count;

  // ----------------------------------------------------------
  // shift register, payload only
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (sample_i)
      frame_q <= {ps2_data_s_i, frame_q[frame_bits-1:1]};
  end

  // ----------------------------------------------------------
  // bit counter
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || frame_done_o)
      bit_count <= '0;
    else if (expired_i)
      bit_count <= '0;                       // drop a half frame
    else if (sample_i)
      bit_count <= bit_count + bit_count_t'(1);
  end

  assign frame_done_o = (bit_count == bit_count_t'(frame_bits));
  assign code_o       = frame_q[8:1];        // skip start, parity, stop

endmodule

`default_nettype wire

/* logic/ps2_code_tracker.sv */
/*
  prefix holds for extended and release codes, shift key state,
  host output registers and the data-ready flag
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_code_tracker #(
  parameter bit trap_shift_keys = 1'b0  // 1 hides shift presses from the host
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                frame_done_i,
  input  ps2_pkg::scan_code_t code_i,
  input  ps2_pkg::scan_code_t ascii_i,
  input  logic                rx_read_i,
  output ps2_pkg::scan_code_t code_o,
  output logic                shift_on_o,
  output ps2_pkg::scan_code_t rx_scan_code_o,
  output ps2_pkg::scan_code_t rx_ascii_o,
  output logic                rx_extended_o,
  output logic                rx_released_o,
  output logic                rx_shift_key_on_o,
  output logic                rx_data_ready_o
);

  import ps2_pkg::*;

  logic is_extend;
  logic is_release;
  logic is_left;
  logic is_right;
  logic key_event;      // finished frame that is a real key
  logic report;         // key event the host gets to see
  logic hold_extended;
  logic hold_released;
  logic left_shift;
  logic right_shift;

  assign is_extend  = (code_i == extend_code);
  assign is_release = (code_i == release_code);
  assign is_left    = (code_i == left_shift_code);
  assign is_right   = (code_i == right_shift_code);

  assign key_event = frame_done_i && !is_extend && !is_release;
  assign report    = key_event && (!trap_shift_keys || !(is_left || is_right));

  // ----------------------------------------------------------
  // prefix holds, cleared by the key that follows
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || key_event)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done_i)
    begin
      if (is_extend)
        hold_extended <= 1'b1;
      if (is_release)
        hold_released <= 1'b1;
    end
  end

  // press sets, release clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (key_event)
    begin
      if (is_left)
        left_shift <= !hold_released;
      if (is_right)
        right_shift <= !hold_released;
    end
  end

  assign shift_on_o        = left_shift || right_shift;
  assign rx_shift_key_on_o = shift_on_o;
  assign code_o            = code_i;  // table translates with current shift state

  // ----------------------------------------------------------
  // host outputs
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code_o <= '0;
      rx_ascii_o     <= '0;
      rx_extended_o  <= 1'b0;
      rx_released_o  <= 1'b0;
    end
    else if (report)
    begin
      rx_scan_code_o <= code_i;
      rx_ascii_o     <= ascii_i;
      rx_extended_o  <= hold_extended;
      rx_released_o  <= hold_released;
    end
  end

  // level flag, a new key overrides a pending read
  always_ff @(posedge clk)
  begin
    if (reset)
      rx_data_ready_o <= 1'b0;
    else if (report)
      rx_data_ready_o <= 1'b1;
    else if (rx_read_i)
      rx_data_ready_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* logic/ps2_ascii_table.sv */
/*
  scan code to ascii translation, keyed on shift state and code
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_ascii_table (
  input  ps2_pkg::scan_code_t code_i,
  input  logic                shift_on_i,
  output ps2_pkg::scan_code_t ascii_o
);

  import ps2_pkg::*;

  logic [8:0] key;  // shift in bit 8

  assign key = {shift_on_i, code_i};

  always_comb
  begin
    casez (key)
      // control keys, same either way
      {1'b?, 8'h66}: ascii_o = 8'h08;  // backspace
      {1'b?, 8'h0d}: ascii_o = 8'h09;  // tab
      {1'b?, 8'h5a}: ascii_o = 8'h0d;  // enter
      {1'b?, 8'h76}: ascii_o = 8'h1b;  // esc
      {1'b?, 8'h29}: ascii_o = 8'h20;  // space
      {1'b?, 8'h71}: ascii_o = 8'h7f;  // delete
      // ----------------------------------------------------------
      // punctuation
      // ----------------------------------------------------------
      9'h116: ascii_o = 8'h21;  // !
      9'h152: ascii_o = 8'h22;  // double quote
      9'h126: ascii_o = 8'h23;  // #
      9'h125: ascii_o = 8'h24;  // $
      9'h12e: ascii_o = 8'h25;  // %
      9'h13d: ascii_o = 8'h26;  // &
      9'h052: ascii_o = 8'h27;  // single quote
      9'h146: ascii_o = 8'h28;
      9'h145: ascii_o = 8'h29;
      9'h13e: ascii_o = 8'h2a;  // *
      9'h155: ascii_o = 8'h2b;  // +
      9'h041: ascii_o = 8'h2c;
      9'h04e: ascii_o = 8'h2d;
      9'h049: ascii_o = 8'h2e;  // period
      9'h04a: ascii_o = 8'h2f;  // slash
      9'h14c: ascii_o = 8'h3a;
      9'h04c: ascii_o = 8'h3b;
      9'h141: ascii_o = 8'h3c;  // <
      9'h055: ascii_o = 8'h3d;  // =
      9'h149: ascii_o = 8'h3e;  // >
      9'h14a: ascii_o = 8'h3f;  // ?
      9'h11e: ascii_o = 8'h40;  // @
      9'h054: ascii_o = 8'h5b;  // open bracket
      9'h05d: ascii_o = 8'h5c;  // backslash
      9'h05b: ascii_o = 8'h5d;  // close bracket
      9'h136: ascii_o = 8'h5e;  // caret
      9'h14e: ascii_o = 8'h5f;  // underscore
      9'h00e: ascii_o = 8'h60;  // backtick
      9'h154: ascii_o = 8'h7b;  // open brace
      9'h15d: ascii_o = 8'h7c;  // pipe
      9'h15b: ascii_o = 8'h7d;  // close brace
      9'h10e: ascii_o = 8'h7e;  // tilde
      // digits, unshifted only
      9'h045: ascii_o = 8'h30;
      9'h016: ascii_o = 8'h31;
      9'h01e: ascii_o = 8'h32;
      9'h026: ascii_o = 8'h33;
      9'h025: ascii_o = 8'h34;
      9'h02e: ascii_o = 8'h35;
      9'h036: ascii_o = 8'h36;
      9'h03d: ascii_o = 8'h37;
      9'h03e: ascii_o = 8'h38;
      9'h046: ascii_o = 8'h39;
      // ----------------------------------------------------------
      // letters, upper case with shift and lower case without
      // ----------------------------------------------------------
      9'h11c: ascii_o = 8'h41;  // A
      9'h132: ascii_o = 8'h42;
      9'h121: ascii_o = 8'h43;
      9'h123: ascii_o = 8'h44;
      9'h124: ascii_o = 8'h45;
      9'h12b: ascii_o = 8'h46;
      9'h134: ascii_o = 8'h47;
      9'h133: ascii_o = 8'h48;
      9'h143: ascii_o = 8'h49;
      9'h13b: ascii_o = 8'h4a;
      9'h142: ascii_o = 8'h4b;
      9'h14b: ascii_o = 8'h4c;
      9'h13a: ascii_o = 8'h4d;
      9'h131: ascii_o = 8'h4e;
      9'h144: ascii_o = 8'h4f;
      9'h14d: ascii_o = 8'h50;
      9'h115: ascii_o = 8'h51;
      9'h12d: ascii_o = 8'h52;
      9'h11b: ascii_o = 8'h53;
      9'h12c: ascii_o = 8'h54;
      9'h13c: ascii_o = 8'h55;
      9'h12a: ascii_o = 8'h56;
      9'h11d: ascii_o = 8'h57;
      9'h122: ascii_o = 8'h58;
      9'h135: ascii_o = 8'h59;
      9'h11a: ascii_o = 8'h5a;  // Z
      9'h01c: ascii_o = 8'h61;  // a
      9'h032: ascii_o = 8'h62;
      9'h021: ascii_o = 8'h63;
      9'h023: ascii_o = 8'h64;
      9'h024: ascii_o = 8'h65;
      9'h02b: ascii_o = 8'h66;
      9'h034: ascii_o = 8'h67;
      9'h033: ascii_o = 8'h68;
      9'h043: ascii_o = 8'h69;
      9'h03b: ascii_o = 8'h6a;
      9'h042: ascii_o = 8'h6b;
      9'h04b: ascii_o = 8'h6c;
      9'h03a: ascii_o = 8'h6d;
      9'h031: ascii_o = 8'h6e;
      9'h044: ascii_o = 8'h6f;
      9'h04d: ascii_o = 8'h70;
      9'h015: ascii_o = 8'h71;
      9'h02d: ascii_o = 8'h72;
      9'h01b: ascii_o = 8'h73;
      9'h02c: ascii_o = 8'h74;
      9'h03c: ascii_o = 8'h75;
      9'h02a: ascii_o = 8'h76;
      9'h01d: ascii_o = 8'h77;
      9'h022: ascii_o = 8'h78;
      9'h035: ascii_o = 8'h79;
      9'h01a: ascii_o = 8'h7a;  // z
      default: ascii_o = ascii_unknown;
    endcase
  end

endmodule

`default_nettype wire

/* logic/ps2_keyboard_rx.sv */
/*
  receive-only ps2 keyboard interface, top level
  clock tracking fsm, watchdog, frame shifter, code tracker, ascii table
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx #(
  parameter int unsigned watchdog_cycles = 2950,  // idle clk cycles before a frame is dropped
  parameter bit          trap_shift_keys = 1'b0
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk_i,
  input  logic                ps2_data_i,
  input  logic                rx_read_i,
  output ps2_pkg::scan_code_t rx_scan_code_o,
  output ps2_pkg::scan_code_t rx_ascii_o,
  output logic                rx_extended_o,
  output logic                rx_released_o,
  output logic                rx_shift_key_on_o,
  output logic                rx_data_ready_o
);

  import ps2_pkg::*;

  logic       sample;       // falling edge strobe
  logic       ps2_data_s;
  logic       idle_high;
  logic       expired;
  logic       frame_done;
  scan_code_t frame_code;   // byte from the shifter
  scan_code_t table_code;   // byte into the ascii table
  logic       shift_on;
  scan_code_t ascii;

  ps2_rx_fsm u_ps2_rx_fsm (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_i    (ps2_clk_i),
    .ps2_data_i   (ps2_data_i),
    .sample_o     (sample),
    .ps2_data_s_o (ps2_data_s),
    .idle_high_o  (idle_high)
  );

  ps2_watchdog_timer #(
    .watchdog_cycles (watchdog_cycles)
  ) u_ps2_watchdog_timer (
    .clk         (clk),
    .reset       (reset),
    .idle_high_i (idle_high),
    .expired_o   (expired)
  );

  ps2_frame_shifter u_ps2_frame_shifter (
    .clk          (clk),
    .reset        (reset),
    .sample_i     (sample),
    .ps2_data_s_i (ps2_data_s),
    .expired_i    (expired),
    .frame_done_o (frame_done),
    .code_o       (frame_code)
  );

  ps2_code_tracker #(
    .trap_shift_keys (trap_shift_keys)
  ) u_ps2_code_tracker (
    .clk               (clk),
    .reset             (reset),
    .frame_done_i      (frame_done),
    .code_i            (frame_code),
    .ascii_i           (ascii),
    .rx_read_i         (rx_read_i),
    .code_o            (table_code),
    .shift_on_o        (shift_on),
    .rx_scan_code_o    (rx_scan_code_o),
    .rx_ascii_o        (rx_ascii_o),
    .rx_extended_o     (rx_extended_o),
    .rx_released_o     (rx_released_o),
    .rx_shift_key_on_o (rx_shift_key_on_o),
    .rx_data_ready_o   (rx_data_ready_o)
  );

  ps2_ascii_table u_ps2_ascii_table (
    .code_i     (table_code),
    .shift_on_i (shift_on),
    .ascii_o    (ascii)
  );

endmodule

`default_nettype wire

/* dv/ps2_keyboard_rx_properties.sv */
/*
  concurrent assertions on the host side of the receiver,
  bound into the top level
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx_properties #(
  parameter bit trap_shift_keys = 1'b0
) (
  input logic                clk,
  input logic                reset,
  input logic                rx_read_i,
  input ps2_pkg::scan_code_t rx_scan_code_o,
  input logic                rx_data_ready_o
);

  import ps2_pkg::*;

  int unsigned failures = 0;  // read by the testbench at the end

  a_reset_ready: assert property (@(posedge clk) reset |=> !rx_data_ready_o)
    else
    begin
      failures++;
      $error("data ready high after reset");
    end

  a_read_clears: assert property (@(posedge clk) disable iff (reset)
    rx_data_ready_o && rx_read_i |=> !rx_data_ready_o)
    else
    begin
      failures++;
      $error("data ready not cleared by the read");
    end

  // prefixes only set holds, never reach the host
  a_no_prefix: assert property (@(posedge clk) disable iff (reset)
    $rose(rx_data_ready_o) |-> rx_scan_code_o != extend_code &&
                               rx_scan_code_o != release_code)
    else
    begin
      failures++;
      $error("prefix code reported to the host");
    end

  a_shift_trap: assert property (@(posedge clk) disable iff (reset)
    $rose(rx_data_ready_o) |-> !trap_shift_keys ||
      (rx_scan_code_o != left_shift_code && rx_scan_code_o != right_shift_code))
    else
    begin
      failures++;
      $error("trapped shift key reported to the host");
    end

endmodule

bind ps2_keyboard_rx ps2_keyboard_rx_properties #(
  .trap_shift_keys (trap_shift_keys)
) u_ps2_keyboard_rx_properties (
  .clk             (clk),
  .reset           (reset),
  .rx_read_i       (rx_read_i),
  .rx_scan_code_o  (rx_scan_code_o),
  .rx_data_ready_o (rx_data_ready_o)
);

`default_nettype wire

/* dv/ps2_keyboard_rx_tb.sv */
/*
  testbench for the ps2 keyboard receiver
  clock and reset, lfsr key picks, keyboard frame driver,
  reference model of prefixes, shift state and ascii, output checks
*/
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx_tb;

  localparam int cycle_limit = 12000;  // ~42 frames of ~240 cycles
  localparam bit trap_shift  = 1'b1;

  logic       clk;
  logic       reset;
  logic       kbd_clk;
  logic       kbd_data;
  logic       rx_read;
  logic [7:0] rx_scan_code;
  logic [7:0] rx_ascii;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic       rx_data_ready;

  int          checks      = 0;
  int          errors      = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state  = 32'h4cb6;
  logic        shift_l     = 1'b0;  // model of the shift keys
  logic        shift_r     = 1'b0;
  logic        ext_hold    = 1'b0;  // model of the prefix holds
  logic        rel_hold    = 1'b0;

  // reference keys, us layout, last entry is a code with no ascii
  logic [7:0] key_code  [0:12] = '{8'h1C, 8'h32, 8'h21, 8'h2D, 8'h1A, 8'h44, 8'h16,
                                   8'h1E, 8'h26, 8'h45, 8'h36, 8'h3D, 8'h05};
  logic [7:0] key_lower [0:12] = '{8'h61, 8'h62, 8'h63, 8'h72, 8'h7A, 8'h6F, 8'h31,
                                   8'h32, 8'h33, 8'h30, 8'h36, 8'h37, 8'h2E};
  logic [7:0] key_upper [0:12] = '{8'h41, 8'h42, 8'h43, 8'h52, 8'h5A, 8'h4F, 8'h21,
                                   8'h40, 8'h23, 8'h29, 8'h5E, 8'h26, 8'h2E};

  ps2_keyboard_rx #(
    .watchdog_cycles (40),
    .trap_shift_keys (trap_shift)
  ) u_ps2_keyboard_rx (
    .clk               (clk),
    .reset             (reset),
    .ps2_clk_i         (kbd_clk),
    .ps2_data_i        (kbd_data),
    .rx_read_i         (rx_read),
    .rx_scan_code_o    (rx_scan_code),
    .rx_ascii_o        (rx_ascii),
    .rx_extended_o     (rx_extended),
    .rx_released_o     (rx_released),
    .rx_shift_key_on_o (rx_shift_key_on),
    .rx_data_ready_o   (rx_data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit)
    begin
      $display("run stopped, no finish after %0d clock cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // random picks and reference model
  // ------------------------------------------------------------
  function automatic logic [7:0] lfsr_bits(input int n);
    logic       fb;
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};  // taps 32 22 2 1
      v          = {v[6:0], fb};
    end
    return v;
  endfunction

  function automatic logic [7:0] pick_key();
    return key_code[lfsr_bits(4) % 13];
  endfunction

  function automatic logic [7:0] model_ascii(input logic [7:0] code, input logic shifted);
    logic [7:0] result;
    result = 8'h2E;  // anything unlisted reads as '.'
    for (int i = 0; i < 13; i++)
      if (key_code[i] == code)
        result = shifted ? key_upper[i] : key_lower[i];
    return result;
  endfunction

  task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // keyboard side
  // ------------------------------------------------------------
  task automatic send_bits(input logic [10:0] bits, input int count);
    for (int i = 0; i < count; i++)
    begin
      @(posedge clk);
      kbd_data <= bits[i];            // data moves while clock is high
      repeat (7) @(posedge clk);
      kbd_clk <= 1'b0;
      repeat (8) @(posedge clk);
      kbd_clk <= 1'b1;
    end
    @(posedge clk);
    kbd_data <= 1'b1;                 // back to idle
  endtask

  // idle time between frames, nothing may be reported here
  task automatic quiet_gap(input string name);
    repeat (60)
    begin
      @(negedge clk);
      checks++;
      assert (!rx_data_ready)
      else
      begin
        errors++;
        $display("%s: data ready high with no key to report", name);
      end
    end
  endtask

  task automatic check_report(input string name, input logic [7:0] code,
                              input logic [7:0] ascii, input logic ext,
                              input logic rel, input int hold);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rx_data_ready && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    checks++;
    assert (rx_data_ready)
    else
    begin
      errors++;
      $display("%s: data ready never rose", name);
    end
    expect_value({name, " scan code"}, code, rx_scan_code);
    expect_value({name, " ascii"}, ascii, rx_ascii);
    expect_value({name, " extended"}, ext, rx_extended);
    expect_value({name, " released"}, rel, rx_released);
    repeat (hold)
    begin
      @(negedge clk);
      checks++;
      assert (rx_data_ready)
      else
      begin
        errors++;
        $display("%s: data ready fell with no read", name);
      end
    end
    @(posedge clk);
    rx_read <= 1'b1;                  // one-cycle read strobe
    @(posedge clk);
    rx_read <= 1'b0;
    @(negedge clk);
    checks++;
    assert (!rx_data_ready)
    else
    begin
      errors++;
      $display("%s: data ready still high one cycle after the read", name);
    end
  endtask

  // sends one code and checks what the host should see
  task automatic send_code(input string name, input logic [7:0] code, input int hold);
    logic       report;
    logic       is_prefix;
    logic [7:0] exp_ascii;
    report    = 1'b0;
    is_prefix = (code == 8'hF0) || (code == 8'hE0);
    exp_ascii = model_ascii(code, shift_l || shift_r);
    if (code == 8'hF0)
      rel_hold = 1'b1;
    else if (code == 8'hE0)
      ext_hold = 1'b1;
    else if (code == 8'h12 || code == 8'h59)
    begin
      if (code == 8'h12)
        shift_l = !rel_hold;          // release prefix clears the key
      else
        shift_r = !rel_hold;
      report = !trap_shift;
    end
    else
      report = 1'b1;
    send_bits({1'b1, ~^code, code, 1'b0}, 11);  // stop, odd parity, data, start
    if (report)
      check_report(name, code, exp_ascii, ext_hold, rel_hold, hold);
    if (!is_prefix)
    begin
      ext_hold = 1'b0;
      rel_hold = 1'b0;
    end
    quiet_gap(name);
    expect_value({name, " shift on"}, shift_l || shift_r, rx_shift_key_on);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial
  begin
    reset    = 1'b1;
    kbd_clk  = 1'b1;
    kbd_data = 1'b1;
    rx_read  = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    repeat (20) send_code("plain key", pick_key(), 0);
    send_code("unlisted key", 8'h05, 0);

    send_code("release prefix", 8'hF0, 0);
    send_code("release prefix", pick_key(), 0);
    send_code("after release", pick_key(), 0);

    send_code("extended prefix", 8'hE0, 0);
    send_code("extended prefix", pick_key(), 0);
    send_code("extended release", 8'hE0, 0);
    send_code("extended release", 8'hF0, 0);
    send_code("extended release", pick_key(), 0);

    send_code("left shift", 8'h12, 0);
    send_code("left shift key", pick_key(), 0);
    send_code("left shift key", pick_key(), 0);
    send_code("left shift up", 8'hF0, 0);
    send_code("left shift up", 8'h12, 0);
    send_code("right shift", 8'h59, 0);
    send_code("right shift key", pick_key(), 0);
    send_code("right shift up", 8'hF0, 0);
    send_code("right shift up", 8'h59, 0);
    send_code("after shift", pick_key(), 0);

    // four bits then silence, the watchdog drops them
    send_bits({1'b1, 1'b0, 8'h1C, 1'b0}, 4);
    quiet_gap("watchdog");
    send_code("watchdog", pick_key(), 0);

    send_code("read handshake", pick_key(), 20);

    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             u_ps2_keyboard_rx.u_ps2_keyboard_rx_properties.failures);
    if (errors == 0 && u_ps2_keyboard_rx.u_ps2_keyboard_rx_properties.failures == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
logic/ps2_pkg.sv
logic/ps2_rx_fsm.sv
logic/ps2_watchdog_timer.sv
logic/ps2_frame_shifter.sv
logic/ps2_code_tracker.sv
logic/ps2_ascii_table.sv
logic/ps2_keyboard_rx.sv
dv/ps2_keyboard_rx_properties.sv
dv/ps2_keyboard_rx_tb.sv
